/* src/rp_pkg.sv */
package rp_pkg;

  //////////////////////////////////////////////////////////////////////////
  // widths and bus map
  //////////////////////////////////////////////////////////////////////////

  localparam int SMP_W      = 14;        // ADC/DAC sample width
  localparam int BUS_AW     = 32;
  localparam int BUS_DW     = 32;
  localparam int REGION_LSB = 20;        // region field starts here
  localparam int REGION_W   = 3;         // address bits 22..20
  localparam int N_REGIONS  = 8;
  localparam int KP_W       = 16;        // controller gain width
  localparam int KP_SHIFT   = 8;         // gain is Q8.8
  localparam int SAT_W      = 32;        // input width of the clamp

  localparam logic [REGION_W-1:0] REGION_HK   = 3'd0;
  localparam logic [REGION_W-1:0] REGION_GEN  = 3'd1;
  localparam logic [REGION_W-1:0] REGION_CTRL = 3'd2;

  // offsets within a region
  localparam logic [REGION_LSB-1:0] REG_ID_OFS   = 20'h00;
  localparam logic [REGION_LSB-1:0] REG_LOOP_OFS = 20'h04;  // bit 0 is digital_loop
  localparam logic [REGION_LSB-1:0] REG_CH_A_OFS = 20'h00;  // gen and ctrl
  localparam logic [REGION_LSB-1:0] REG_CH_B_OFS = 20'h04;

  localparam logic [BUS_DW-1:0] HK_ID = 32'h5250_0001;

  // clamp limits, held wide so they compare directly with the clamp input
  localparam logic signed [SAT_W-1:0] SMP_MAX = 2**(SMP_W-1) - 1;
  localparam logic signed [SAT_W-1:0] SMP_MIN = -(2**(SMP_W-1));

  typedef logic signed [SMP_W-1:0] sample_t;
  typedef logic signed [SMP_W:0]   sum_t;     // one guard bit
  typedef logic signed [KP_W-1:0]  kp_t;

  // negative slope offset code -> two's complement
  function automatic sample_t offset_to_sample(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  // two's complement -> offset code, same bit flip
  function automatic logic [SMP_W-1:0] sample_to_offset(input sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  // clamp a wide signed value into sample range
  function automatic sample_t sat_sample(input logic signed [SAT_W-1:0] v);
    if (v > SMP_MAX)
      return SMP_MAX[SMP_W-1:0];
    else if (v < SMP_MIN)
      return SMP_MIN[SMP_W-1:0];
    else
      return v[SMP_W-1:0];
  endfunction

endpackage

/* src/sys_bus_decoder.sv */
`timescale 1ns/1ps

module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              reset_i,
  // wishbone request from master
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic [BUS_AW-1:0] wb_adr_i,
  // per region strobes
  output logic              hk_stb_o,
  output logic              gen_stb_o,
  output logic              ctrl_stb_o,
  // slave answers
  input  logic              hk_ack_i,
  input  logic              gen_ack_i,
  input  logic              ctrl_ack_i,
  input  logic [BUS_DW-1:0] hk_rdat_i,
  input  logic [BUS_DW-1:0] gen_rdat_i,
  input  logic [BUS_DW-1:0] ctrl_rdat_i,
  // back to master
  output logic              wb_ack_o,
  output logic [BUS_DW-1:0] wb_dat_o
);

  logic [REGION_W-1:0]  region;     // address bits 22..20
  logic [N_REGIONS-1:0] cs;         // one-hot region select
  logic [N_REGIONS-1:0] ack_vec;    // ack per region
  logic                 req;        // live bus cycle
  logic                 unused_stb; // regions 3..7
  logic                 unused_ack;

  assign region = wb_adr_i[REGION_LSB +: REGION_W];
  assign cs     = N_REGIONS'(1) << region;
  assign req    = wb_cyc_i & wb_stb_i;

  assign hk_stb_o   = req & cs[REGION_HK];
  assign gen_stb_o  = req & cs[REGION_GEN];
  assign ctrl_stb_o = req & cs[REGION_CTRL];
  assign unused_stb = req & ~(cs[REGION_HK] | cs[REGION_GEN] | cs[REGION_CTRL]);

  ////////////////////////////////////////////////////////////////////////////
  // unused regions answer themselves
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      unused_ack <= 1'b0;
    else
      unused_ack <= unused_stb & ~unused_ack;  // single cycle pulse
  end

  // the shared unused ack is masked by cs below
  always_comb
  begin
    ack_vec              = {N_REGIONS{unused_ack}};
    ack_vec[REGION_HK]   = hk_ack_i;
    ack_vec[REGION_GEN]  = gen_ack_i;
    ack_vec[REGION_CTRL] = ctrl_ack_i;
  end

  assign wb_ack_o = |(cs & ack_vec);

  // read data mux, zero for regions 3..7
  always_comb
  begin
    case (region)
      REGION_HK:   wb_dat_o = hk_rdat_i;
      REGION_GEN:  wb_dat_o = gen_rdat_i;
      REGION_CTRL: wb_dat_o = ctrl_rdat_i;
      default:     wb_dat_o = '0;
    endcase
  end

endmodule

/* src/housekeeping.sv */
`timescale 1ns/1ps

module housekeeping
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // bus slave port
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [REGION_LSB-1:0] adr_i,   // offset within region
  input  logic [BUS_DW-1:0]     dat_i,
  output logic [BUS_DW-1:0]     dat_o,
  output logic                  ack_o,
  // global config
  output logic                  digital_loop_o
);

  logic access;  // first strobe cycle of a transfer

  assign access = stb_i & ~ack_o;

  // control state: ack and loop flag
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o          <= 1'b0;
      digital_loop_o <= 1'b0;
    end
    else
    begin
      ack_o <= access;
      if (access && we_i && adr_i == REG_LOOP_OFS)
        digital_loop_o <= dat_i[0];  // other bits ignored
    end
  end

  // read data lands with ack
  always_ff @(posedge adc_clk)
  begin
    if (access)
    begin
      case (adr_i)
        REG_ID_OFS:   dat_o <= HK_ID;
        REG_LOOP_OFS: dat_o <= {{(BUS_DW-1){1'b0}}, digital_loop_o};
        default:      dat_o <= '0;  // unmapped reads zero
      endcase
    end
  end

endmodule

/* src/adc_frontend.sv */
`timescale 1ns/1ps

module adc_frontend
  import rp_pkg::*;
(
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic [SMP_W-1:0] adc_dat_a_i,     // raw pins, offset code
  input  logic [SMP_W-1:0] adc_dat_b_i,
  input  logic             digital_loop_i,
  input  sample_t          loop_a_i,        // saturated DAC sum
  input  sample_t          loop_b_i,
  output sample_t          adc_a_o,
  output sample_t          adc_b_o
);

  logic [SMP_W-1:0] adc_dat_a;  // pin registers
  logic [SMP_W-1:0] adc_dat_b;

  // input capture, one cycle
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_dat_a <= '0;
      adc_dat_b <= '0;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i;
      adc_dat_b <= adc_dat_b_i;
    end
  end

  // loopback bypasses the pins, no extra register
  assign adc_a_o = digital_loop_i ? loop_a_i : offset_to_sample(adc_dat_a);
  assign adc_b_o = digital_loop_i ? loop_b_i : offset_to_sample(adc_dat_b);

endmodule

/* src/level_gen.sv */
`timescale 1ns/1ps

module level_gen
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // bus slave port
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [REGION_LSB-1:0] adr_i,
  input  logic [BUS_DW-1:0]     dat_i,
  output logic [BUS_DW-1:0]     dat_o,
  output logic                  ack_o,
  // DC levels to the DAC sum
  output sample_t               gen_a_o,
  output sample_t               gen_b_o
);

  logic access;

  assign access = stb_i & ~ack_o;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o   <= 1'b0;
      gen_a_o <= '0;
      gen_b_o <= '0;
    end
    else
    begin
      ack_o <= access;
      if (access && we_i)
      begin
        case (adr_i)
          REG_CH_A_OFS: gen_a_o <= dat_i[SMP_W-1:0];  // low 14 bits
          REG_CH_B_OFS: gen_b_o <= dat_i[SMP_W-1:0];
          default: ;                                  // write dropped
        endcase
      end
    end
  end

  // readback sign extended
  always_ff @(posedge adc_clk)
  begin
    if (access)
    begin
      case (adr_i)
        REG_CH_A_OFS: dat_o <= {{(BUS_DW-SMP_W){gen_a_o[SMP_W-1]}}, gen_a_o};
        REG_CH_B_OFS: dat_o <= {{(BUS_DW-SMP_W){gen_b_o[SMP_W-1]}}, gen_b_o};
        default:      dat_o <= '0;
      endcase
    end
  end

endmodule

/* src/prop_ctrl.sv */
`timescale 1ns/1ps

module prop_ctrl
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // bus slave port
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [REGION_LSB-1:0] adr_i,
  input  logic [BUS_DW-1:0]     dat_i,
  output logic [BUS_DW-1:0]     dat_o,
  output logic                  ack_o,
  // data path
  input  sample_t               adc_a_i,
  input  sample_t               adc_b_i,
  output sample_t               ctrl_a_o,
  output sample_t               ctrl_b_o
);

  logic                     access;
  kp_t                      kp_a;     // per channel gain, Q8.8
  kp_t                      kp_b;
  logic signed [SAT_W-1:0]  prod_a;   // 30 significant bits
  logic signed [SAT_W-1:0]  prod_b;

  assign access = stb_i & ~ack_o;

  ////////////////////////////////////////////////////////////////////////////
  // gain registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o <= 1'b0;
      kp_a  <= '0;
      kp_b  <= '0;
    end
    else
    begin
      ack_o <= access;
      if (access && we_i)
      begin
        case (adr_i)
          REG_CH_A_OFS: kp_a <= dat_i[KP_W-1:0];
          REG_CH_B_OFS: kp_b <= dat_i[KP_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (access)
    begin
      case (adr_i)
        REG_CH_A_OFS: dat_o <= {{(BUS_DW-KP_W){kp_a[KP_W-1]}}, kp_a};
        REG_CH_B_OFS: dat_o <= {{(BUS_DW-KP_W){kp_b[KP_W-1]}}, kp_b};
        default:      dat_o <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // proportional term
  ////////////////////////////////////////////////////////////////////////////

  // both operands signed, extended to 32 bits before the multiply
  assign prod_a = adc_a_i * kp_a;
  assign prod_b = adc_b_i * kp_b;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ctrl_a_o <= '0;
      ctrl_b_o <= '0;
    end
    else
    begin
      ctrl_a_o <= sat_sample(prod_a >>> KP_SHIFT);  // arithmetic shift, then clamp
      ctrl_b_o <= sat_sample(prod_b >>> KP_SHIFT);
    end
  end

endmodule

/* src/dac_backend.sv */
`timescale 1ns/1ps

module dac_backend
  import rp_pkg::*;
(
  input  logic             adc_clk,
  input  logic             reset_i,
  input  sample_t          gen_a_i,    // level generator
  input  sample_t          gen_b_i,
  input  sample_t          ctrl_a_i,   // controller
  input  sample_t          ctrl_b_i,
  output logic [SMP_W-1:0] dac_a_o,    // offset code to pins
  output logic [SMP_W-1:0] dac_b_o,
  output sample_t          loop_a_o,   // saturated sum, unregistered
  output sample_t          loop_b_o
);

  sum_t sum_a;  // one bit wider, can't overflow
  sum_t sum_b;

  assign sum_a = gen_a_i + ctrl_a_i;
  assign sum_b = gen_b_i + ctrl_b_i;

  // clamp back to 14 bits, also feeds loopback
  assign loop_a_o = sat_sample(sum_a);
  assign loop_b_o = sat_sample(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // output register, two's complement -> negative slope offset code
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_a_o <= sample_to_offset(sample_t'(0));  // 0x1FFF, mid scale
      dac_b_o <= sample_to_offset(sample_t'(0));
    end
    else
    begin
      dac_a_o <= sample_to_offset(loop_a_o);
      dac_b_o <= sample_to_offset(loop_b_o);
    end
  end

endmodule

/* src/rp_top.sv */
`timescale 1ns/1ps

module rp_top
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              reset_i,
  // wishbone classic slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [BUS_AW-1:0] wb_adr_i,
  input  logic [BUS_DW-1:0] wb_dat_i,
  output logic [BUS_DW-1:0] wb_dat_o,
  output logic              wb_ack_o,
  // converters
  input  logic [SMP_W-1:0]  adc_dat_a_i,
  input  logic [SMP_W-1:0]  adc_dat_b_i,
  output logic [SMP_W-1:0]  dac_a_o,
  output logic [SMP_W-1:0]  dac_b_o
);

  logic              hk_stb, gen_stb, ctrl_stb;
  logic              hk_ack, gen_ack, ctrl_ack;
  logic [BUS_DW-1:0] hk_rdat, gen_rdat, ctrl_rdat;
  logic              digital_loop;
  sample_t           adc_a, adc_b;    // converted or looped samples
  sample_t           gen_a, gen_b;    // DC levels
  sample_t           ctrl_a, ctrl_b;  // controller outputs
  sample_t           loop_a, loop_b;  // saturated DAC sums

  ////////////////////////////////////////////////////////////////////////////
  // system bus, regions 0..2 live, 3..7 answer zero
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder u_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_adr_i    (wb_adr_i),
    .hk_stb_o    (hk_stb),
    .gen_stb_o   (gen_stb),
    .ctrl_stb_o  (ctrl_stb),
    .hk_ack_i    (hk_ack),
    .gen_ack_i   (gen_ack),
    .ctrl_ack_i  (ctrl_ack),
    .hk_rdat_i   (hk_rdat),
    .gen_rdat_i  (gen_rdat),
    .ctrl_rdat_i (ctrl_rdat),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o)
  );

  housekeeping u_housekeeping (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .stb_i          (hk_stb),
    .we_i           (wb_we_i),
    .adr_i          (wb_adr_i[REGION_LSB-1:0]),  // offset only
    .dat_i          (wb_dat_i),
    .dat_o          (hk_rdat),
    .ack_o          (hk_ack),
    .digital_loop_o (digital_loop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // analog path: ADC reg -> ctrl reg -> DAC reg
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (loop_a),
    .loop_b_i       (loop_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  level_gen u_level_gen (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .stb_i   (gen_stb),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i[REGION_LSB-1:0]),
    .dat_i   (wb_dat_i),
    .dat_o   (gen_rdat),
    .ack_o   (gen_ack),
    .gen_a_o (gen_a),
    .gen_b_o (gen_b)
  );

  prop_ctrl u_prop_ctrl (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .stb_i    (ctrl_stb),
    .we_i     (wb_we_i),
    .adr_i    (wb_adr_i[REGION_LSB-1:0]),
    .dat_i    (wb_dat_i),
    .dat_o    (ctrl_rdat),
    .ack_o    (ctrl_ack),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .ctrl_a_o (ctrl_a),
    .ctrl_b_o (ctrl_b)
  );

  dac_backend u_dac_backend (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .gen_a_i  (gen_a),
    .gen_b_i  (gen_b),
    .ctrl_a_i (ctrl_a),
    .ctrl_b_i (ctrl_b),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o),
    .loop_a_o (loop_a),
    .loop_b_o (loop_b)
  );

endmodule

/* sim/tb_rp_top.sv */
`timescale 1ns/1ps

module tb_rp_top
  import rp_pkg::*;
();

  localparam int CLK_HALF   = 10;                        // 20 ns period
  localparam int MAX_CYCLES = 4000;                      // tests need ~950 cycles
  localparam int SMP_HI     = (1 << (SMP_W-1)) - 1;
  localparam int SMP_LO     = -(1 << (SMP_W-1));

  logic              adc_clk;
  logic              reset_i;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [BUS_AW-1:0] wb_adr;
  logic [BUS_DW-1:0] wb_wdat;
  logic [BUS_DW-1:0] wb_rdat;
  logic              wb_ack;
  logic [SMP_W-1:0]  pin_drv [2];                        // ADC pins, offset code
  logic [SMP_W-1:0]  dac_a;
  logic [SMP_W-1:0]  dac_b;

  // reference model state
  sample_t           m_level [2];
  kp_t               m_gain [2];
  sample_t           m_ctrl [2];                         // registered controller out
  logic [SMP_W-1:0]  m_pin_reg [2];
  logic [SMP_W-1:0]  m_dac [2];
  logic              m_loop;
  logic [15:0]       lfsr;
  string             test_name;
  int                cycle_cnt;

  rp_top u_rp_top (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_wdat),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack),
    .adc_dat_a_i (pin_drv[0]),
    .adc_dat_b_i (pin_drv[1]),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_HALF) adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    stop_run();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    stop_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////////////////////

  // sign bit kept, lower 13 inverted, same both ways
  function automatic logic [SMP_W-1:0] flip_code(input logic [SMP_W-1:0] x);
    return x ^ {1'b0, {(SMP_W-1){1'b1}}};
  endfunction

  function automatic sample_t clamp_sample(input int v);
    if (v > SMP_HI)
      return sample_t'(SMP_HI);
    else if (v < SMP_LO)
      return sample_t'(SMP_LO);
    return sample_t'(v);
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [BUS_AW-1:0] bus_addr(input int region, input int ofs);
    return BUS_AW'(region << REGION_LSB) | BUS_AW'(ofs);
  endfunction

  // channel of an offset, -1 if unmapped
  function automatic int chan_of(input logic [BUS_AW-1:0] adr);
    if (adr[REGION_LSB-1:0] == REG_CH_A_OFS)
      return 0;
    else if (adr[REGION_LSB-1:0] == REG_CH_B_OFS)
      return 1;
    return -1;
  endfunction

  function automatic logic [BUS_DW-1:0] model_read(input logic [BUS_AW-1:0] adr);
    int ch;
    ch = chan_of(adr);
    case (adr[REGION_LSB +: 3])
      REGION_HK:
        if (adr[REGION_LSB-1:0] == REG_ID_OFS)
          return HK_ID;
        else if (adr[REGION_LSB-1:0] == REG_LOOP_OFS)
          return BUS_DW'(m_loop);
      REGION_GEN:
        if (ch >= 0)
          return int'(m_level[ch]);                      // sign extended
      REGION_CTRL:
        if (ch >= 0)
          return int'(m_gain[ch]);
      default: ;
    endcase
    return '0;                                           // unused region or offset
  endfunction

  task automatic model_write(input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] dat);
    int ch;
    ch = chan_of(adr);
    case (adr[REGION_LSB +: 3])
      REGION_HK:
        if (adr[REGION_LSB-1:0] == REG_LOOP_OFS)
          m_loop = dat[0];
      REGION_GEN:
        if (ch >= 0)
          m_level[ch] = dat[SMP_W-1:0];                  // low 14 bits
      REGION_CTRL:
        if (ch >= 0)
          m_gain[ch] = dat[KP_W-1:0];
      default: ;
    endcase
  endtask

  // one clock; model acts on pre-edge values, DAC checked every cycle
  task automatic tick();
    sample_t sum_s;
    sample_t in_s;
    int      prod;
    @(posedge adc_clk);
    for (int ch = 0; ch < 2; ch++)
    begin
      sum_s = clamp_sample(int'(m_level[ch]) + int'(m_ctrl[ch]));
      in_s  = m_loop ? sum_s : sample_t'(flip_code(m_pin_reg[ch]));  // loop skips pins
      prod  = int'(in_s) * int'(m_gain[ch]);
      m_dac[ch]     = flip_code(sum_s);
      m_ctrl[ch]    = clamp_sample(prod >>> KP_SHIFT);
      m_pin_reg[ch] = pin_drv[ch];
    end
    #1;
    assert (dac_a == m_dac[0]) else report_mismatch("dac_a", 32'(m_dac[0]), 32'(dac_a));
    assert (dac_b == m_dac[1]) else report_mismatch("dac_b", 32'(m_dac[1]), 32'(dac_b));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic [BUS_AW-1:0] adr, input logic we,
                           input logic [BUS_DW-1:0] dat, output logic [BUS_DW-1:0] rdat);
    int waited;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    waited  = 0;
    do
    begin
      tick();
      waited++;
    end
    while (!wb_ack && waited < 8);
    assert (wb_ack) else report_error("no ack within 8 cycles");
    assert (waited == 1) else report_mismatch("ack latency", 32'd1, 32'(waited));
    rdat = wb_rdat;                                      // data comes with ack
    if (we)
      model_write(adr, dat);                             // captured on the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    tick();
    assert (!wb_ack) else report_error("ack high for more than one cycle");
  endtask

  task automatic wb_write(input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] dat);
    logic [BUS_DW-1:0] unused_rdat;
    bus_cycle(adr, 1'b1, dat, unused_rdat);
  endtask

  task automatic wb_read(input logic [BUS_AW-1:0] adr);
    logic [BUS_DW-1:0] rdat;
    bus_cycle(adr, 1'b0, '0, rdat);
    assert (rdat == model_read(adr)) else report_mismatch("read data", model_read(adr), rdat);
  endtask

  task automatic check_regs();
    wb_read(bus_addr(REGION_HK, REG_ID_OFS));
    wb_read(bus_addr(REGION_HK, REG_LOOP_OFS));
    for (int r = REGION_GEN; r <= REGION_CTRL; r++)
    begin
      wb_read(bus_addr(r, REG_CH_A_OFS));
      wb_read(bus_addr(r, REG_CH_B_OFS));
      wb_read(bus_addr(r, 'h08));                        // unmapped offset
    end
  endtask

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);                            // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic run_random(input int n);
    logic [31:0] v;
    repeat (n)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        draw_bits(SMP_W, v);
        pin_drv[ch] = v[SMP_W-1:0];
      end
      tick();
    end
  endtask

  task automatic setup_path(input logic [31:0] lvl_a, input logic [31:0] lvl_b,
                            input logic [31:0] kp_a, input logic [31:0] kp_b);
    wb_write(bus_addr(REGION_GEN, REG_CH_A_OFS), lvl_a);
    wb_write(bus_addr(REGION_GEN, REG_CH_B_OFS), lvl_b);
    wb_write(bus_addr(REGION_CTRL, REG_CH_A_OFS), kp_a);
    wb_write(bus_addr(REGION_CTRL, REG_CH_B_OFS), kp_b);
    check_regs();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    reset_i    = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_wdat    = '0;
    pin_drv[0] = 14'h1FFF;                               // offset code of zero
    pin_drv[1] = 14'h1FFF;
    for (int ch = 0; ch < 2; ch++)
    begin
      m_level[ch]   = '0;
      m_gain[ch]    = '0;
      m_ctrl[ch]    = '0;
      m_pin_reg[ch] = '0;                                // pin regs reset to zero
      m_dac[ch]     = 14'h1FFF;
    end
    m_loop    = 1'b0;
    lfsr      = 16'd68;
    test_name = "reset_state";
    repeat (8) @(posedge adc_clk);
    #1;
    reset_i = 1'b0;

    assert (!wb_ack) else report_error("ack high right after reset");
    assert (dac_a == 14'h1FFF) else report_mismatch("dac_a", 32'h1FFF, 32'(dac_a));
    assert (dac_b == 14'h1FFF) else report_mismatch("dac_b", 32'h1FFF, 32'(dac_b));
    wb_read(bus_addr(REGION_HK, REG_ID_OFS));
    wb_read(bus_addr(REGION_HK, REG_LOOP_OFS));

    test_name = "level_gen";                             // gains still zero
    setup_path(32'h0000_1234, 32'hFFFF_2ABC, 32'h0, 32'h0);
    setup_path(32'h0000_1FFF, 32'h0000_2000, 32'h0, 32'h0);  // extremes
    setup_path(32'hFFFF_E000, 32'hABCD_1FFF, 32'h0, 32'h0);  // upper bits dropped

    test_name = "unused_regions";
    for (int r = 3; r < 8; r++)
    begin
      wb_read(bus_addr(r, 0));
      wb_read(bus_addr(r, 4));
      wb_write(bus_addr(r, 0), 32'hFFFF_FFFF);
      wb_write(bus_addr(r, 4), 32'h0000_0001);           // would set loop if misdecoded
    end
    wb_write(bus_addr(REGION_GEN, 'h08), 32'h0000_0555);
    wb_write(bus_addr(REGION_CTRL, 'h0C), 32'h0000_0100);
    wb_write(bus_addr(REGION_HK, REG_ID_OFS), 32'h0);    // ID is read only
    check_regs();

    test_name = "prop_path";
    setup_path(32'h0, 32'h0, 32'h0000_0100, 32'h0000_FF00);              // +1.0, -1.0
    run_random(150);
    setup_path(32'h0000_0800, 32'h0000_3800, 32'h0000_0380, 32'h0000_FE40);
    run_random(150);
    setup_path(32'h0000_1F00, 32'h0000_2100, 32'h0000_7FFF, 32'h0000_8000); // saturating
    run_random(150);
    setup_path(32'h0000_1FF0, 32'h0000_2010, 32'h0000_0040, 32'h0000_FFC0);
    run_random(150);

    test_name = "loopback";
    setup_path(32'h0000_0400, 32'h0000_3C00, 32'h0000_00C0, 32'h0000_0180);
    wb_write(bus_addr(REGION_HK, REG_LOOP_OFS), 32'h0000_0001);
    wb_read(bus_addr(REGION_HK, REG_LOOP_OFS));
    run_random(50);                                      // pins toggle, must not matter
    wb_write(bus_addr(REGION_HK, REG_LOOP_OFS), 32'h0000_0000);
    wb_read(bus_addr(REGION_HK, REG_LOOP_OFS));
    run_random(30);                                      // pin path back

    $display("Verification passed");
    $finish;
  end

  // watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles, stuck in %s", MAX_CYCLES, test_name);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

/* project.f */
src/rp_pkg.sv
src/sys_bus_decoder.sv
src/housekeeping.sv
src/adc_frontend.sv
src/level_gen.sv
src/prop_ctrl.sv
src/dac_backend.sv
src/rp_top.sv
sim/tb_rp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rp_top \
    -f project.f -o tb_rp_top \
  && ./obj_dir/tb_rp_top | tee sim.log \
  && grep -qx "Verification passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL: see sim.log"; exit 1; }
